// File: source/pipe_pkg.sv
package pipe_pkg;

  // basic widths
  localparam int PC_W    = 8;   // pc counts instruction words
  localparam int INSTR_W = 16;
  localparam int REG_W   = 4;   // register field width
  localparam int IMM_W   = 2 * REG_W;  // imm built from rs1 and rs2

  // toy opcode set, upper nibble of the instruction
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ALU   = 4'd1,
    OP_LOAD  = 4'd2,
    OP_JUMP  = 4'd3,
    OP_MUL   = 4'd4,
    OP_ECALL = 4'd5,
    OP_CSR   = 4'd6
  } op_e;

  // bit positions in the stall and flush vectors
  // bit 5 has no stage behind it and stays spare
  localparam int STG_PC     = 0;
  localparam int STG_IF_ID  = 1;
  localparam int STG_ID_EX  = 2;
  localparam int STG_EX_MEM = 3;
  localparam int STG_MEM_WB = 4;

  // controller table, one stall and one flush pattern per hazard
  localparam logic [5:0] LOAD_USE_STALL = 6'b000011;  // hold pc and if_id
  localparam logic [5:0] LOAD_USE_FLUSH = 6'b000100;  // one bubble into ex
  localparam logic [5:0] JUMP_STALL     = 6'b000000;
  localparam logic [5:0] JUMP_FLUSH     = 6'b000110;  // kill the two younger ones
  localparam logic [5:0] MUL_STALL      = 6'b000111;  // hold up to ex
  localparam logic [5:0] MUL_FLUSH      = 6'b001000;  // bubble behind the mul
  localparam logic [5:0] CSR_STALL      = 6'b111111;  // freeze the whole pipe
  localparam logic [5:0] CSR_FLUSH      = 6'b000000;
  localparam logic [5:0] ECALL_STALL    = 6'b000000;
  localparam logic [5:0] ECALL_FLUSH    = 6'b111111;  // drop everything younger
  localparam logic [5:0] RAM_STALL      = 6'b011111;  // wait holds all stages
  localparam logic [5:0] RAM_FLUSH      = 6'b000000;

  // multicycle lengths
  localparam int MUL_CYCLES = 3;  // extra cycles a mul spends in ex
  localparam int CSR_CYCLES = 2;  // cycles a csr freezes the pipe from wb
  localparam int MUL_CNT_W  = $clog2(MUL_CYCLES + 1);
  localparam int CSR_CNT_W  = $clog2(CSR_CYCLES + 1);

  localparam logic [PC_W-1:0] TRAP_VECTOR = 8'hF0;  // ecall target

  // if to id
  typedef struct packed {
    logic               valid;
    logic [PC_W-1:0]    pc;
    logic [INSTR_W-1:0] instr;
  } fetch_t;

  // id to ex, reused for ex_mem and mem_wb
  typedef struct packed {
    logic             valid;
    logic [PC_W-1:0]  pc;
    op_e              op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [IMM_W-1:0] imm;
  } dec_t;

endpackage

// File: source/stage_reg.sv
module stage_reg #(
  parameter type payload_t = logic  // fetch_t or dec_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,  // keep current contents
  input  logic     flush_i,  // load a bubble
  input  payload_t d_i,
  output payload_t q_o
);

  // one boundary between two stages
  // an all zero payload is a bubble since valid sits inside it
  always_ff @(posedge clk) begin
    if (rst) begin
      q_o <= '0;
    end else if (flush_i) begin
      q_o <= '0;  // flush beats stall
    end else if (!stall_i) begin
      q_o <= d_i;
    end
    // stalled and not flushed keeps q_o
  end

endmodule

// File: source/pipe_control.sv
module pipe_control import pipe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       imem_wait_i,       // fetch ram not ready
  input  logic       dmem_wait_i,       // data ram not ready
  input  logic       load_use_i,        // from id
  input  logic       jump_i,            // from ex
  input  logic       mul_busy_i,        // from ex
  input  logic       wb_valid_i,        // mem_wb payload
  input  op_e        wb_op_i,
  output logic [5:0] stall_o,           // one bit per stage boundary
  output logic [5:0] flush_o,
  output logic       ecall_redirect_o   // fetch goes to the trap vector
);

  logic                 ram_req;
  logic                 ecall_req;
  logic                 csr_in_wb;
  logic                 csr_req;
  logic [CSR_CNT_W-1:0] csr_cnt_q;  // cycles the csr has frozen the pipe

  assign ram_req   = imem_wait_i | dmem_wait_i;
  assign ecall_req = wb_valid_i && (wb_op_i == OP_ECALL);
  assign csr_in_wb = wb_valid_i && (wb_op_i == OP_CSR);
  assign csr_req   = csr_in_wb && (csr_cnt_q != CSR_CNT_W'(CSR_CYCLES));

  // later stage wins
  always_comb begin
    stall_o          = '0;
    flush_o          = '0;
    ecall_redirect_o = 1'b0;
    if (rst) begin
      flush_o = '1;  // everything empty while in reset
    end else if (ram_req) begin
      stall_o = RAM_STALL;
      flush_o = RAM_FLUSH;
    end else if (ecall_req) begin
      stall_o          = ECALL_STALL;
      flush_o          = ECALL_FLUSH;
      ecall_redirect_o = 1'b1;  // ecall itself retires this cycle
    end else if (csr_req) begin
      stall_o = CSR_STALL;
      flush_o = CSR_FLUSH;
    end else if (jump_i) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (mul_busy_i) begin
      stall_o = MUL_STALL;
      flush_o = MUL_FLUSH;
    end else if (load_use_i) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end
  end

  // csr freeze length
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_cnt_q <= '0;
    end else if (!csr_in_wb) begin
      csr_cnt_q <= '0;
    end else if (csr_req) begin
      csr_cnt_q <= csr_cnt_q + 1'b1;
    end else if (!stall_o[STG_MEM_WB]) begin
      csr_cnt_q <= '0;  // csr leaves wb now
    end
  end

  // no boundary is asked to hold and bubble at once
  a_no_stall_and_flush: assert property (@(posedge clk) disable iff (rst)
    (stall_o & flush_o) == '0);

  // trap squashes if_id and leaves wb empty behind the ecall
  a_ecall_squash: assert property (@(posedge clk) disable iff (rst)
    ecall_redirect_o |-> flush_o[STG_IF_ID] ##1 !wb_valid_i);

endmodule

// File: source/fetch_unit.sv
module fetch_unit import pipe_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall_i,           // stall bit of the pc
  input  logic               jump_i,            // taken jump in ex
  input  logic [PC_W-1:0]    target_i,
  input  logic               ecall_redirect_i,  // trap from wb
  output logic [PC_W-1:0]    fetch_pc_o,        // to instruction ram
  input  logic [INSTR_W-1:0] fetch_instr_i,     // same cycle answer
  output fetch_t             fetch_o            // into if_id
);

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_d;

  // next pc
  always_comb begin
    if (ecall_redirect_i) begin
      pc_d = TRAP_VECTOR;  // trap beats everything
    end else if (stall_i) begin
      pc_d = pc_q;
    end else if (jump_i) begin
      pc_d = target_i;
    end else begin
      pc_d = pc_q + 1'b1;  // word addressed
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign fetch_pc_o = pc_q;

  // whatever comes back is a live fetch
  // imem wait is handled by the controller holding if_id
  assign fetch_o.valid = 1'b1;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.instr = fetch_instr_i;

  // held pc only moves for a trap
  a_pc_hold: assert property (@(posedge clk) disable iff (rst)
    (stall_i && !ecall_redirect_i) |=> $stable(pc_q));

endmodule

// File: source/decode_stage.sv
module decode_stage import pipe_pkg::*; (
  input  fetch_t if_id_i,     // instruction in id
  input  dec_t   id_ex_i,     // older instruction now in ex
  output dec_t   dec_o,
  output logic   load_use_o   // needs one bubble
);

  op_e              op;
  logic [REG_W-1:0] rd;
  logic [REG_W-1:0] rs1;
  logic [REG_W-1:0] rs2;
  logic             consumer;  // reads rs1 or rs2
  logic             ex_load;
  logic             dep_hit;

  // opcode nibble, unknown codes decode as nop
  always_comb begin
    case (if_id_i.instr[15:12])
      4'd1:    op = OP_ALU;
      4'd2:    op = OP_LOAD;
      4'd3:    op = OP_JUMP;
      4'd4:    op = OP_MUL;
      4'd5:    op = OP_ECALL;
      4'd6:    op = OP_CSR;
      default: op = OP_NOP;
    endcase
  end

  assign rd  = if_id_i.instr[11:8];
  assign rs1 = if_id_i.instr[7:4];
  assign rs2 = if_id_i.instr[3:0];

  // jump, ecall and csr read no registers here
  assign consumer = (op == OP_ALU) || (op == OP_LOAD) || (op == OP_MUL);

  assign ex_load = id_ex_i.valid && (id_ex_i.op == OP_LOAD);
  assign dep_hit = (id_ex_i.rd == rs1) || (id_ex_i.rd == rs2);

  // load data not ready until after mem
  assign load_use_o = if_id_i.valid && consumer && ex_load && dep_hit;

  assign dec_o.valid = if_id_i.valid;
  assign dec_o.pc    = if_id_i.pc;
  assign dec_o.op    = op;
  assign dec_o.rd    = rd;
  assign dec_o.rs1   = rs1;
  assign dec_o.rs2   = rs2;
  assign dec_o.imm   = {rs1, rs2};  // jump offset

endmodule

// File: source/execute_stage.sv
module execute_stage import pipe_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  dec_t            id_ex_i,     // instruction in ex
  input  logic            stall_i,     // stall bit of id_ex
  output logic            jump_o,      // redirect request
  output logic [PC_W-1:0] target_o,
  output logic            mul_busy_o   // keep the mul in ex
);

  logic                 mul_in_ex;
  logic [MUL_CNT_W-1:0] mul_cnt_q;  // extra cycles already spent

  // jumps are always taken
  assign jump_o   = id_ex_i.valid && (id_ex_i.op == OP_JUMP);
  assign target_o = id_ex_i.pc + id_ex_i.imm;  // wraps in pc space

  assign mul_in_ex  = id_ex_i.valid && (id_ex_i.op == OP_MUL);
  assign mul_busy_o = mul_in_ex && (mul_cnt_q != MUL_CNT_W'(MUL_CYCLES));

  // multiply latency
  // a flushed mul turns into a bubble and that clears the count
  always_ff @(posedge clk) begin
    if (rst) begin
      mul_cnt_q <= '0;
    end else if (!mul_in_ex) begin
      mul_cnt_q <= '0;
    end else if (mul_busy_o) begin
      mul_cnt_q <= mul_cnt_q + 1'b1;
    end else if (!stall_i) begin
      mul_cnt_q <= '0;  // done and moving to mem
    end
    // done but held by a later stage keeps the count
  end

  // busy drops after MUL_CYCLES even when the pipe is frozen around it
  a_mul_bounded: assert property (@(posedge clk) disable iff (rst)
    mul_busy_o [*MUL_CYCLES] |=> !mul_busy_o);

endmodule

// File: source/pipe_top.sv
module pipe_top import pipe_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  output logic [PC_W-1:0]    fetch_pc_o,     // instruction ram address
  input  logic [INSTR_W-1:0] fetch_instr_i,
  input  logic               imem_wait_i,
  input  logic               dmem_wait_i,
  output logic               retire_valid_o,  // one strobe per instruction
  output logic [PC_W-1:0]    retire_pc_o,
  output op_e                retire_op_o
);

  logic [5:0]      stall;
  logic [5:0]      flush;
  logic            load_use;
  logic            jump;
  logic [PC_W-1:0] jump_target;
  logic            mul_busy;
  logic            ecall_redirect;

  fetch_t if_d;   // fetch out
  fetch_t if_q;   // if_id
  dec_t   id_d;   // decode out
  dec_t   id_q;   // id_ex
  dec_t   ex_q;   // ex_mem
  dec_t   mem_q;  // mem_wb

  pipe_control u_pipe_control (
    .clk              (clk),
    .rst              (rst),
    .imem_wait_i      (imem_wait_i),
    .dmem_wait_i      (dmem_wait_i),
    .load_use_i       (load_use),
    .jump_i           (jump),
    .mul_busy_i       (mul_busy),
    .wb_valid_i       (mem_q.valid),
    .wb_op_i          (mem_q.op),
    .stall_o          (stall),
    .flush_o          (flush),
    .ecall_redirect_o (ecall_redirect)
  );

  fetch_unit u_fetch_unit (
    .clk              (clk),
    .rst              (rst),
    .stall_i          (stall[STG_PC]),
    .jump_i           (jump),
    .target_i         (jump_target),
    .ecall_redirect_i (ecall_redirect),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_instr_i    (fetch_instr_i),
    .fetch_o          (if_d)
  );

  stage_reg #(.payload_t(fetch_t)) u_if_id (
    .clk(clk), .rst(rst), .stall_i(stall[STG_IF_ID]), .flush_i(flush[STG_IF_ID]),
    .d_i(if_d), .q_o(if_q)
  );

  decode_stage u_decode_stage (
    .if_id_i    (if_q),
    .id_ex_i    (id_q),
    .dec_o      (id_d),
    .load_use_o (load_use)
  );

  stage_reg #(.payload_t(dec_t)) u_id_ex (
    .clk(clk), .rst(rst), .stall_i(stall[STG_ID_EX]), .flush_i(flush[STG_ID_EX]),
    .d_i(id_d), .q_o(id_q)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .rst        (rst),
    .id_ex_i    (id_q),
    .stall_i    (stall[STG_ID_EX]),
    .jump_o     (jump),
    .target_o   (jump_target),
    .mul_busy_o (mul_busy)
  );

  // ex and mem pass the payload on unchanged
  stage_reg #(.payload_t(dec_t)) u_ex_mem (
    .clk(clk), .rst(rst), .stall_i(stall[STG_EX_MEM]), .flush_i(flush[STG_EX_MEM]),
    .d_i(id_q), .q_o(ex_q)
  );

  stage_reg #(.payload_t(dec_t)) u_mem_wb (
    .clk(clk), .rst(rst), .stall_i(stall[STG_MEM_WB]), .flush_i(flush[STG_MEM_WB]),
    .d_i(ex_q), .q_o(mem_q)
  );

  // held wb entry retires only once it is let go
  assign retire_valid_o = mem_q.valid && !stall[STG_MEM_WB];
  assign retire_pc_o    = mem_q.pc;
  assign retire_op_o    = mem_q.op;

endmodule

// File: verification/pipe_tb.sv
module pipe_tb import pipe_pkg::*; ();

  logic               clk = 1'b0;
  logic               rst;
  logic [PC_W-1:0]    fetch_pc;
  logic [INSTR_W-1:0] fetch_instr;
  logic               imem_wait;
  logic               dmem_wait;
  logic               retire_valid;
  logic [PC_W-1:0]    retire_pc;
  op_e                retire_op;

  logic [INSTR_W-1:0] imem [256];  // covers the whole pc space

  // expected and observed retire streams
  logic [PC_W-1:0] exp_pc[$];
  op_e             exp_op[$];
  logic [PC_W-1:0] got_pc[$];
  op_e             got_op[$];
  int              got_cyc[$];  // strobe cycle, 0 is the fetch of pc 0

  string cur_test;
  int    num_checks;
  int    num_errors;

  pipe_top u_pipe_top (
    .clk            (clk),
    .rst            (rst),
    .fetch_pc_o     (fetch_pc),
    .fetch_instr_i  (fetch_instr),
    .imem_wait_i    (imem_wait),
    .dmem_wait_i    (dmem_wait),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_op_o    (retire_op)
  );

  assign fetch_instr = imem[fetch_pc];  // answers in the same cycle

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [INSTR_W-1:0] encode(input op_e op, input int rd,
                                                 input int rs1, input int rs2);
    return {op, rd[3:0], rs1[3:0], rs2[3:0]};
  endfunction

  task automatic check_equal(input string what, input int expected, input int actual);
    num_checks++;
    assert (actual == expected) else begin
      num_errors++;
      $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    num_checks++;
    assert (cond) else begin
      num_errors++;
      $display("%s: %s", cur_test, msg);
    end
  endtask

  task automatic clear_mem;
    for (int a = 0; a < 256; a++) begin
      imem[a] = '0;  // nop everywhere, so every program ends
    end
  endtask

  // architectural walk of the program, stops at the first nop
  task automatic build_model;
    logic [PC_W-1:0]    pc;
    logic [INSTR_W-1:0] ins;
    int                 steps;
    exp_pc.delete();
    exp_op.delete();
    pc = '0;
    steps = 0;
    ins = imem[pc];
    while (ins[15:12] != 4'd0 && steps < 64) begin
      exp_pc.push_back(pc);
      exp_op.push_back(op_e'(ins[15:12]));
      case (ins[15:12])
        OP_JUMP:  pc = pc + ins[7:0];  // imm is rs1 and rs2
        OP_ECALL: pc = TRAP_VECTOR;
        default:  pc = pc + 1'b1;
      endcase
      steps++;
      ins = imem[pc];
    end
  endtask

  // reset, then collect strobes until the sentinel nop retires
  task automatic run_program(input bit rand_wait);
    int cyc;
    bit done;
    got_pc.delete();
    got_op.delete();
    got_cyc.delete();
    build_model();
    imem_wait = 1'b0;
    dmem_wait = 1'b0;
    rst = 1'b1;
    repeat (5) @(negedge clk);
    check_true(fetch_pc == '0, "pc is not 0 after reset");
    check_true(!retire_valid, "retire strobe seen during reset");
    rst = 1'b0;  // pc 0 is fetched in this cycle
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < 400) begin
      @(negedge clk);
      cyc++;
      if (rand_wait) begin
        imem_wait = ($urandom % 4) == 0;
        dmem_wait = ($urandom % 4) == 0;
      end
      #1;  // strobe now reflects the wait of this cycle
      if (retire_valid && retire_op == OP_NOP) begin
        done = 1'b1;
      end else if (retire_valid) begin
        got_pc.push_back(retire_pc);
        got_op.push_back(retire_op);
        got_cyc.push_back(cyc);
      end
    end
    @(negedge clk);
    imem_wait = 1'b0;
    dmem_wait = 1'b0;
    check_true(done, "timeout, the nop sentinel never retired");
  endtask

  task automatic compare_lists;
    check_equal("retire count", exp_pc.size(), got_pc.size());
    for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
      check_equal($sformatf("retire %0d pc", i), exp_pc[i], got_pc[i]);
      check_equal($sformatf("retire %0d op", i), exp_op[i], got_op[i]);
    end
  endtask

  // back to back retires, a mul or csr arrives its extra cycles late
  task automatic check_gaps;
    int extra;
    for (int i = 1; i < got_cyc.size() && i < exp_op.size(); i++) begin
      extra = 0;
      if (exp_op[i] == OP_MUL) begin
        extra = MUL_CYCLES;
      end
      if (exp_op[i] == OP_CSR) begin
        extra = CSR_CYCLES;
      end
      check_equal($sformatf("gap before retire %0d", i), 1 + extra,
                  got_cyc[i] - got_cyc[i-1]);
    end
  endtask

  task automatic test_straight;
    cur_test = "test_straight";
    clear_mem();
    for (int a = 0; a < 6; a++) begin
      imem[a] = encode(OP_ALU, a + 1, a, a + 2);
    end
    run_program(1'b0);
    compare_lists();
    if (got_cyc.size() > 0) begin
      check_equal("first retire cycle", 4, got_cyc[0]);
    end
    check_gaps();
  endtask

  task automatic test_load_use;
    cur_test = "test_load_use";
    clear_mem();
    imem[0] = encode(OP_LOAD, 1, 2, 3);
    imem[1] = encode(OP_ALU, 4, 1, 5);  // reads r1 right behind the load
    imem[2] = encode(OP_ALU, 6, 7, 8);
    run_program(1'b0);
    compare_lists();
    if (got_cyc.size() > 2) begin
      check_equal("load to consumer gap", 2, got_cyc[1] - got_cyc[0]);  // one bubble
      check_equal("consumer to next gap", 1, got_cyc[2] - got_cyc[1]);
    end
  endtask

  task automatic test_jump;
    cur_test = "test_jump";
    clear_mem();
    for (int a = 0; a < 7; a++) begin
      imem[a] = encode(OP_ALU, a + 1, 0, 0);
    end
    imem[1] = encode(OP_JUMP, 0, 0, 4);  // lands on pc 5
    run_program(1'b0);
    compare_lists();
    foreach (got_pc[i]) begin
      check_true(got_pc[i] != 2 && got_pc[i] != 3, "an instruction behind the jump retired");
    end
    if (got_pc.size() > 2) begin
      check_equal("pc after jump", 1 + 4, got_pc[2]);
    end
  endtask

  task automatic test_mul_csr;
    cur_test = "test_mul_csr";
    clear_mem();
    for (int a = 0; a < 7; a++) begin
      imem[a] = encode(OP_ALU, a + 1, 0, 0);
    end
    imem[1] = encode(OP_MUL, 2, 3, 4);
    imem[4] = encode(OP_CSR, 0, 0, 0);
    run_program(1'b0);
    compare_lists();
    check_gaps();
  endtask

  task automatic test_ecall;
    cur_test = "test_ecall";
    clear_mem();
    for (int a = 0; a < 6; a++) begin
      imem[a] = encode(OP_ALU, a + 1, 0, 0);
    end
    imem[1] = encode(OP_ECALL, 0, 0, 0);
    imem[TRAP_VECTOR] = encode(OP_ALU, 9, 0, 0);      // trap handler
    imem[TRAP_VECTOR + 1] = encode(OP_ALU, 10, 0, 0);
    run_program(1'b0);
    compare_lists();
    foreach (got_pc[i]) begin
      check_true(got_pc[i] < 2 || got_pc[i] > 5, "an instruction younger than the ecall retired");
    end
    if (got_pc.size() > 2) begin
      check_equal("pc after ecall", TRAP_VECTOR, got_pc[2]);
    end
  endtask

  task automatic test_ram_wait;
    cur_test = "test_ram_wait";
    clear_mem();
    imem[0]  = encode(OP_ALU, 1, 0, 0);
    imem[1]  = encode(OP_LOAD, 2, 1, 0);
    imem[2]  = encode(OP_ALU, 3, 2, 1);   // load-use on r2
    imem[3]  = encode(OP_MUL, 4, 3, 1);
    imem[4]  = encode(OP_JUMP, 0, 0, 3);  // to pc 7
    imem[5]  = encode(OP_ALU, 5, 0, 0);   // skipped
    imem[6]  = encode(OP_ALU, 6, 0, 0);   // skipped
    imem[7]  = encode(OP_CSR, 0, 0, 0);
    imem[8]  = encode(OP_ALU, 7, 4, 3);
    imem[9]  = encode(OP_LOAD, 5, 7, 0);
    imem[10] = encode(OP_MUL, 6, 5, 5);   // mul as the consumer
    imem[11] = encode(OP_ECALL, 0, 0, 0);
    imem[12] = encode(OP_ALU, 8, 0, 0);   // squashed by the trap
    imem[TRAP_VECTOR] = encode(OP_ALU, 9, 6, 0);
    repeat (3) begin
      run_program(1'b1);  // fresh wait pattern each round
      compare_lists();
    end
  endtask

  initial begin
    rst = 1'b1;
    imem_wait = 1'b0;
    dmem_wait = 1'b0;
    num_checks = 0;
    num_errors = 0;
    void'($urandom(98));  // single seed for the run
    clear_mem();
    test_straight();
    test_load_use();
    test_jump();
    test_mul_csr();
    test_ecall();
    test_ram_wait();
    $display("checks: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: project.f
source/pipe_pkg.sv
source/stage_reg.sv
source/pipe_control.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipe_top.sv
verification/pipe_tb.sv

// File: Bender.yml
package:
  name: pipe

sources:
  - files:
      - source/pipe_pkg.sv
      - source/stage_reg.sv
      - source/pipe_control.sv
      - source/fetch_unit.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/pipe_top.sv
  - target: test
    files:
      - verification/pipe_tb.sv
